//--- fwdUnit.f
src/regPkg.sv
src/pipePkg.sv
src/inputStage.sv
src/stageMirror.sv
src/operandForward.sv
src/regFile.sv
src/fwdUnit.sv
bench/fwdUnitTb.sv

//--- Makefile
# Verilator flow for the forwarding unit: build and run, lint, clean.
# Any variable can be overridden on the command line, e.g. make BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= fwdUnitTb
RTL_TOP   ?= fwdUnit
FILELIST  ?= fwdUnit.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only --timing --timescale $(TIMESCALE)
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

# the run fails unless the pass line shows up in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/fwdTrace.dat
// flags ctrl regA regB cls exuDst exuData exuC mauDst mauData mauC expOpd1 expOpd2 expWait
// flags bit0 = check line, bit1 = random EXU data, bit2 = random MAU data; ctrl = stepExu..workWb
// reset state reads zero
7 00 21 22 0 00 00000000 0 00 00000000 0 00000000 00000000 0
// writes through WB, cond 0 write is dropped
3 08 00 00 0 00 00000000 0 21 11111111 1 00000000 00000000 0
3 09 21 22 0 00 00000000 0 22 22222222 1 11111111 00000000 0
3 09 21 22 0 00 00000000 0 21 bad0bad0 0 11111111 22222222 0
7 01 21 22 0 00 00000000 0 00 00000000 0 11111111 22222222 0
7 00 21 22 0 00 00000000 0 00 00000000 0 11111111 22222222 0
// forwarding priority on r3
3 08 00 00 0 00 00000000 0 23 33330003 1 00000000 00000000 0
1 07 23 23 0 23 33330001 1 23 33330002 1 33330001 33330001 0
3 0b 22 23 0 23 00000000 1 23 33330002 1 22222222 33330002 0
7 01 23 21 0 23 00000000 1 23 00000000 1 33330002 11111111 0
7 00 23 23 0 00 00000000 0 00 00000000 0 33330002 33330002 0
// load in EXU stalls, non-load does not
7 10 00 00 1 00 00000000 0 00 00000000 0 00000000 00000000 0
5 04 25 21 0 25 5555aaaa 1 00 00000000 0 00000000 11111111 1
5 04 21 25 0 25 5555aaaa 1 00 00000000 0 11111111 00000000 1
5 14 25 25 0 25 5555aaaa 1 00 00000000 0 00000000 00000000 1
5 04 25 25 0 25 5555bbbb 1 00 00000000 0 5555bbbb 5555bbbb 0
3 02 25 27 0 25 00000000 1 25 5555cccc 1 5555cccc 00000000 0
// r31 and invalid sources read zero
3 08 00 00 0 00 00000000 0 3f 31313131 1 00000000 00000000 0
1 07 3f 3f 0 3f 3f3f0001 1 3f 3f3f0002 1 00000000 00000000 0
1 07 05 3f 0 25 5555dddd 1 3f 3f3f0003 1 00000000 00000000 0
7 00 01 03 0 00 00000000 0 00 00000000 0 00000000 00000000 0
// cond 0 results skipped for the next source down
1 06 22 21 0 22 2222e0e0 0 22 2222a0a0 1 2222a0a0 11111111 0
1 06 22 21 0 21 1111e0e0 0 21 1111a0a0 0 22222222 11111111 0
3 08 00 00 0 00 00000000 0 22 2222beef 1 00000000 00000000 0
1 07 22 21 0 22 2222e1e1 0 22 2222a1a1 0 2222beef 11111111 0
7 00 22 21 0 00 00000000 0 00 00000000 0 2222beef 11111111 0
// end of trace
ff 00 00 00 0 00 00000000 0 00 00000000 0 00000000 00000000 0

//--- bench/fwdUnitTb.sv
/*
  Testbench of the forwarding unit. Replays bench/fwdTrace.dat one line
  per clock and checks opd1, opd2 and waitForData one cycle later.
  Run from the project root so the trace path resolves.
*/
module fwdUnitTb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int numFields   = 14;                // words per trace line
   localparam int maxLines    = 64;
   localparam int resetCycles = 16;
   localparam logic [31:0] endMark = 32'hff;       // flags word of the closing line

   // word offsets inside one trace line
   localparam int fFlags   = 0;                    // bit0 check, bit1/bit2 random data
   localparam int fCtrl    = 1;
   localparam int fRegA    = 2;
   localparam int fRegB    = 3;
   localparam int fOpClass = 4;
   localparam int fExuDest = 5;
   localparam int fExuData = 6;
   localparam int fExuCond = 7;
   localparam int fMauDest = 8;
   localparam int fMauData = 9;
   localparam int fMauCond = 10;
   localparam int fOpd1    = 11;                   // expected values from here on
   localparam int fOpd2    = 12;
   localparam int fWait    = 13;

   logic               sys_clk = 1'b0;
   logic               rstN;
   pipePkg::pipeCtrlT  ctrl;
   pipePkg::srcPairT   src;
   pipePkg::opClassT   opClass;
   pipePkg::resultT    exuResult;
   pipePkg::resultT    mauResult;
   regPkg::regDataT    opd1;
   regPkg::regDataT    opd2;
   logic               waitForData;

   logic [31:0] traceMem [maxLines*numFields];     // whole trace, flat
   int          numLines;
   int          cycleCnt   = 0;
   int          cycleLimit = maxLines + resetCycles + 20;   // tightened after load
   int          checks     = 0;
   int          opd1Errs   = 0;
   int          opd2Errs   = 0;
   int          waitErrs   = 0;
   int          otherErrs  = 0;
   int unsigned seedVal;

   fwdUnit dut0 (.*);                              // port names match one to one

   always #20 sys_clk = ~sys_clk;                  // 40 ns period

   //////////////////////////////////////////////////////////////////////
   // run limit
   //////////////////////////////////////////////////////////////////////

   always @(posedge sys_clk) begin
      cycleCnt <= cycleCnt + 1;
      if (cycleCnt >= cycleLimit) begin
         $display("Timeout: the trace did not finish within %0d cycles", cycleLimit);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // trace replay
   //////////////////////////////////////////////////////////////////////

   // one trace line onto the DUT inputs, called right after a rising edge
   task automatic driveLine(input int line);
      int              base;
      pipePkg::resultT exuVal;
      pipePkg::resultT mauVal;
      base        = line * numFields;
      exuVal.dest = traceMem[base + fExuDest][5:0];
      exuVal.data = traceMem[base + fExuData];
      exuVal.cond = traceMem[base + fExuCond][0];
      mauVal.dest = traceMem[base + fMauDest][5:0];
      mauVal.data = traceMem[base + fMauData];
      mauVal.cond = traceMem[base + fMauCond][0];
      if (traceMem[base + fFlags][1]) begin
         exuVal.data = $urandom();                 // word never reaches a checked output
      end
      if (traceMem[base + fFlags][2]) begin
         mauVal.data = $urandom();
      end
      ctrl      <= traceMem[base + fCtrl][4:0];
      src       <= {traceMem[base + fRegA][5:0], traceMem[base + fRegB][5:0]};
      opClass   <= pipePkg::opClassT'(traceMem[base + fOpClass][1:0]);
      exuResult <= exuVal;
      mauResult <= mauVal;
   endtask

   // compare outputs with the expected fields of a line captured one edge ago
   task automatic checkLine(input int line);
      int              base;
      regPkg::regDataT expOpd1;
      regPkg::regDataT expOpd2;
      logic            expWait;
      base    = line * numFields;
      expOpd1 = traceMem[base + fOpd1];
      expOpd2 = traceMem[base + fOpd2];
      expWait = traceMem[base + fWait][0];
      if (traceMem[base + fFlags][0]) begin
         checks++;
         if (opd1 !== expOpd1) begin
            opd1Errs++;
            $display("Error %0d ns: opd1 expected %h actual %h (trace line %0d)",
                     $time, expOpd1, opd1, line);
         end
         if (opd2 !== expOpd2) begin
            opd2Errs++;
            $display("Error %0d ns: opd2 expected %h actual %h (trace line %0d)",
                     $time, expOpd2, opd2, line);
         end
         if (waitForData !== expWait) begin
            waitErrs++;
            $display("Error %0d ns: waitForData expected %b actual %b (trace line %0d)",
                     $time, expWait, waitForData, line);
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      rstN      = 1'b0;
      ctrl      = '0;
      src       = '0;
      opClass   = pipePkg::opAlu;
      exuResult = '0;
      mauResult = '0;
      seedVal   = $urandom(70185);                 // single seed for the run
      $readmemh("bench/fwdTrace.dat", traceMem);
      numLines = 0;
      while (numLines < maxLines && traceMem[numLines*numFields + fFlags] != endMark) begin
         numLines++;
      end
      if (numLines == maxLines) begin
         otherErrs++;
         $display("The trace file has no end line or could not be read");
      end
      cycleLimit = numLines + resetCycles + 20;
      repeat (resetCycles) @(posedge sys_clk);
      rstN <= 1'b1;
      // line i is driven now, captured next edge, checked on the falling edge after
      for (int i = 0; i <= numLines; i++) begin
         @(posedge sys_clk);
         if (i < numLines) begin
            driveLine(i);
         end
         @(negedge sys_clk);
         if (i > 0) begin
            checkLine(i - 1);
         end
      end
      if (checks == 0) begin
         otherErrs++;
         $display("No trace line was checked");
      end
      $display("checks %0d, errors opd1 %0d, opd2 %0d, waitForData %0d, other %0d",
               checks, opd1Errs, opd2Errs, waitErrs, otherErrs);
      if (opd1Errs + opd2Errs + waitErrs + otherErrs == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- src/fwdUnit.sv
/*
  Forwarding register unit, top level.
  Registers the pipe inputs, mirrors EXU/WB state, forwards the newest
  result per operand and asks for a stall on a load-use hazard.
*/
module fwdUnit (
   input  logic               sys_clk,
   input  logic               rstN,          // sync, active low
   input  pipePkg::pipeCtrlT  ctrl,          // from pipeline controller
   input  pipePkg::srcPairT   src,           // from decode
   input  pipePkg::opClassT   opClass,       // from decode
   input  pipePkg::resultT    exuResult,     // from EXU
   input  pipePkg::resultT    mauResult,     // from MAU
   output regPkg::regDataT    opd1,          // to EXU, operand A
   output regPkg::regDataT    opd2,          // to EXU, operand B
   output logic               waitForData    // to controller
);

   // registered inputs
   pipePkg::pipeCtrlT ctrlQ;
   pipePkg::srcPairT  srcQ;
   pipePkg::opClassT  opClassQ;
   pipePkg::resultT   exuQ;
   pipePkg::resultT   mauQ;

   // mirror pipe and register file
   logic              exuIsLoad;
   pipePkg::resultT   wbResult;
   regPkg::regDataT   rdDataA, rdDataB;

   //////////////////////////////////////////////////////////////////////
   // sequential part
   //////////////////////////////////////////////////////////////////////

   inputStage inputStage0 (
      .sys_clk   (sys_clk),
      .rstN      (rstN),
      .ctrl      (ctrl),
      .src       (src),
      .opClass   (opClass),
      .exuResult (exuResult),
      .mauResult (mauResult),
      .ctrlQ     (ctrlQ),
      .srcQ      (srcQ),
      .opClassQ  (opClassQ),
      .exuQ      (exuQ),
      .mauQ      (mauQ)
   );

   stageMirror stageMirror0 (
      .sys_clk   (sys_clk),
      .rstN      (rstN),
      .ctrlQ     (ctrlQ),
      .opClassQ  (opClassQ),
      .mauQ      (mauQ),
      .exuIsLoad (exuIsLoad),
      .wbResult  (wbResult)
   );

   regFile regFile0 (
      .sys_clk   (sys_clk),
      .rstN      (rstN),
      .rdAddrA   (srcQ.regA.idx),            // valid bit handled in forwarding
      .rdAddrB   (srcQ.regB.idx),
      .wbResult  (wbResult),
      .workWb    (ctrlQ.workWb),
      .rdDataA   (rdDataA),
      .rdDataB   (rdDataB)
   );

   //////////////////////////////////////////////////////////////////////
   // combinational part
   //////////////////////////////////////////////////////////////////////

   operandForward operandForward0 (
      .srcQ        (srcQ),
      .exuQ        (exuQ),
      .mauQ        (mauQ),
      .wbResult    (wbResult),
      .exuIsLoad   (exuIsLoad),
      .ctrlQ       (ctrlQ),
      .rdDataA     (rdDataA),
      .rdDataB     (rdDataB),
      .opd1        (opd1),
      .opd2        (opd2),
      .waitForData (waitForData)
   );

endmodule

//--- src/regFile.sv
/*
  32-word register file of the forwarding unit.
  Two asynchronous read ports, one write port fed from the WB latch.
  Every word is cleared on each clock edge while rstN is low.
*/
module regFile (
   input  logic                              sys_clk,
   input  logic                              rstN,      // sync, active low
   input  logic [regPkg::regIdxWidth-1:0]    rdAddrA,   // index of regA
   input  logic [regPkg::regIdxWidth-1:0]    rdAddrB,   // index of regB
   input  pipePkg::resultT                   wbResult,  // write port source
   input  logic                              workWb,    // WB holds valid work
   output regPkg::regDataT                   rdDataA,
   output regPkg::regDataT                   rdDataB
);

   localparam int numRegs = 2 ** regPkg::regIdxWidth;   // 32 words

   regPkg::regDataT regs [numRegs];          // storage
   logic            wrEn;                    // write this edge

   // cmov false results and invalid dests never reach the file
   assign wrEn = wbResult.dest.valid && wbResult.cond && workWb;

   //////////////////////////////////////////////////////////////////////
   // write port
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge sys_clk) begin
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;                   // whole file in one edge
         end
      end else if (wrEn) begin
         regs[wbResult.dest.idx] <= wbResult.data;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // read ports
   //////////////////////////////////////////////////////////////////////

   // r31 may hold junk here, the operand mux substitutes zero
   assign rdDataA = regs[rdAddrA];
   assign rdDataB = regs[rdAddrB];

endmodule

//--- src/operandForward.sv
/*
  Operand selection of the forwarding unit, purely combinational.
  Each source address is compared with the EXU, MAU and WB destinations;
  the newest usable result wins, else the register file word is used.
  Also flags a load-use hazard so the controller can stall EXU.
*/
module operandForward (
   input  pipePkg::srcPairT   srcQ,          // registered source pair
   input  pipePkg::resultT    exuQ,          // EXU result, forward prio 1
   input  pipePkg::resultT    mauQ,          // MAU result, prio 2
   input  pipePkg::resultT    wbResult,      // WB latch, prio 3
   input  logic               exuIsLoad,     // EXU data not yet known
   input  pipePkg::pipeCtrlT  ctrlQ,         // only the work bits used here
   input  regPkg::regDataT    rdDataA,       // register file word for regA
   input  regPkg::regDataT    rdDataB,       // register file word for regB
   output regPkg::regDataT    opd1,
   output regPkg::regDataT    opd2,
   output logic               waitForData    // stall request to controller
);

   pipePkg::opdSrcT selA;                    // chosen source of opd1
   pipePkg::opdSrcT selB;                    // chosen source of opd2
   logic            stallA, stallB;          // per operand load hazard

   //////////////////////////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////////////////////////

   // address can be forwarded or read at all
   function automatic logic usable(input regPkg::regAddrT addr);
      return addr.valid && (addr.idx != regPkg::zeroReg);
   endfunction

   // whole address compare with the valid bit included
   function automatic logic destHit(input regPkg::regAddrT addr,
                                    input regPkg::regAddrT dest);
      return addr == dest;
   endfunction

   // priority pick of EXU over MAU over WB over the file
   function automatic pipePkg::opdSrcT pickSrc(input regPkg::regAddrT addr);
      pipePkg::opdSrcT sel;
      if (!usable(addr)) begin
         sel = pipePkg::takeZero;            // r31 or no address
      end else if (destHit(addr, exuQ.dest) && ctrlQ.workExu &&
                   exuQ.cond && !exuIsLoad) begin
         sel = pipePkg::takeExu;             // load data is not here yet
      end else if (destHit(addr, mauQ.dest) && ctrlQ.workMau && mauQ.cond) begin
         sel = pipePkg::takeMau;
      end else if (destHit(addr, wbResult.dest) && ctrlQ.workWb &&
                   wbResult.cond) begin
         sel = pipePkg::takeWb;              // covers the same-cycle write
      end else begin
         sel = pipePkg::takeReg;
      end
      return sel;
   endfunction

   // operand mux
   function automatic regPkg::regDataT muxOpd(input pipePkg::opdSrcT sel,
                                              input regPkg::regDataT rdData);
      regPkg::regDataT opd;
      case (sel)
         pipePkg::takeExu: opd = exuQ.data;
         pipePkg::takeMau: opd = mauQ.data;
         pipePkg::takeWb:  opd = wbResult.data;
         pipePkg::takeReg: opd = rdData;
         default:          opd = '0;         // takeZero
      endcase
      return opd;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // source select and operand muxes
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      selA = pickSrc(srcQ.regA);
      selB = pickSrc(srcQ.regB);
      opd1 = muxOpd(selA, rdDataA);
      opd2 = muxOpd(selB, rdDataB);
   end

   //////////////////////////////////////////////////////////////////////
   // load-use hazard
   //////////////////////////////////////////////////////////////////////

   // a load result is awaited whatever its cond bit
   assign stallA = usable(srcQ.regA) && destHit(srcQ.regA, exuQ.dest) &&
                   ctrlQ.workExu && exuIsLoad;
   assign stallB = usable(srcQ.regB) && destHit(srcQ.regB, exuQ.dest) &&
                   ctrlQ.workExu && exuIsLoad;

   assign waitForData = stallA || stallB;    // controller holds EXU

endmodule

//--- src/stageMirror.sv
/*
  Small mirror of the processor pipe kept inside the forwarding unit.
  Holds the load flag of the EXU instruction and the write-back latch.
*/
module stageMirror (
   input  logic               sys_clk,
   input  logic               rstN,          // sync, active low
   input  pipePkg::pipeCtrlT  ctrlQ,         // registered steps
   input  pipePkg::opClassT   opClassQ,      // registered inst class
   input  pipePkg::resultT    mauQ,          // registered MAU result
   output logic               exuIsLoad,     // EXU inst is a load
   output pipePkg::resultT    wbResult       // result sitting in WB
);

   logic isLoad;                             // class decode for the mirror

   assign isLoad = (opClassQ == pipePkg::opLoad);

   //////////////////////////////////////////////////////////////////////
   // EXU stage
   //////////////////////////////////////////////////////////////////////

   // data of a load is not in EXU, only MAU will have it
   always_ff @(posedge sys_clk) begin
      if (!rstN) begin
         exuIsLoad <= 1'b0;
      end else if (ctrlQ.stepExu) begin
         exuIsLoad <= isLoad;                // held while EXU stalls
      end
   end

   //////////////////////////////////////////////////////////////////////
   // WB stage
   //////////////////////////////////////////////////////////////////////

   // MAU output moves into WB, cond travels with it
   always_ff @(posedge sys_clk) begin
      if (!rstN) begin
         wbResult <= '0;                     // dest invalid, no write
      end else if (ctrlQ.stepWb) begin
         wbResult <= mauQ;
      end
   end

endmodule

//--- src/inputStage.sv
/*
  Input register of the forwarding unit.
  Every port is sampled once per sys_clk so the compare and mux logic
  sees stable values for a whole cycle.
*/
module inputStage (
   input  logic               sys_clk,
   input  logic               rstN,          // sync, active low
   input  pipePkg::pipeCtrlT  ctrl,          // steps and works from controller
   input  pipePkg::srcPairT   src,           // source addresses from decode
   input  pipePkg::opClassT   opClass,       // class of inst entering EXU
   input  pipePkg::resultT    exuResult,     // EXU dest, data, cond
   input  pipePkg::resultT    mauResult,     // MAU dest, data, cond
   output pipePkg::pipeCtrlT  ctrlQ,
   output pipePkg::srcPairT   srcQ,
   output pipePkg::opClassT   opClassQ,
   output pipePkg::resultT    exuQ,
   output pipePkg::resultT    mauQ
);

   //////////////////////////////////////////////////////////////////////
   // control side
   //////////////////////////////////////////////////////////////////////

   // strobes and addresses, cleared so no work looks active after reset
   always_ff @(posedge sys_clk) begin
      if (!rstN) begin
         ctrlQ    <= '0;                     // no step, no work
         srcQ     <= '0;                     // both sources invalid
         opClassQ <= pipePkg::opAlu;         // never a load out of reset
      end else begin
         ctrlQ    <= ctrl;
         srcQ     <= src;
         opClassQ <= opClass;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // result side
   //////////////////////////////////////////////////////////////////////

   // stage results used for forwarding and for the WB latch
   always_ff @(posedge sys_clk) begin
      if (!rstN) begin
         exuQ <= '0;                         // dest invalid, cond 0
         mauQ <= '0;
      end else begin
         exuQ <= exuResult;
         mauQ <= mauResult;
      end
   end

endmodule

//--- src/pipePkg.sv
/*
  Pipeline control definitions for the forwarding unit.
  Step/work strobes, in-flight results, instruction class and the
  per-operand source select. Depends on regPkg.
*/
package pipePkg;

   //////////////////////////////////////////////////////////////////////
   // strobes from the pipeline controller
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic stepExu;       // instruction advances into EXU
      logic stepWb;        // MAU result advances into WB
      logic workExu;       // EXU holds valid work this cycle
      logic workMau;       // MAU holds valid work this cycle
      logic workWb;        // WB holds valid work this cycle
   } pipeCtrlT;            // 5 bits

   //////////////////////////////////////////////////////////////////////
   // result of a stage, with its destination
   //////////////////////////////////////////////////////////////////////

   // cond is 0 only for a conditional move whose condition failed
   typedef struct packed {
      regPkg::regAddrT dest;     // destination, valid bit on top
      regPkg::regDataT data;     // result word
      logic            cond;     // 0 => cmov false, do not use
   } resultT;                    // 39 bits

   // source register pair from decode
   typedef struct packed {
      regPkg::regAddrT regA;     // feeds opd1
      regPkg::regAddrT regB;     // feeds opd2
   } srcPairT;                   // 12 bits

   //////////////////////////////////////////////////////////////////////
   // enums
   //////////////////////////////////////////////////////////////////////

   // class of the instruction entering EXU
   typedef enum logic [1:0] {
      opAlu    = 2'd0,
      opLoad   = 2'd1,     // data only known once MAU has it
      opStore  = 2'd2,
      opBranch = 2'd3
   } opClassT;

   // where an operand is taken from, highest priority first
   typedef enum logic [2:0] {
      takeExu  = 3'd0,
      takeMau  = 3'd1,
      takeWb   = 3'd2,
      takeReg  = 3'd3,
      takeZero = 3'd4      // r31 or invalid address
   } opdSrcT;

endpackage

//--- src/regPkg.sv
/*
  Architectural register definitions for the forwarding unit.
  Word width, register index width and the hardwired zero register.
  Compile this package before pipePkg and before any module.
*/
package regPkg;

   //////////////////////////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////////////////////////

   localparam int dataWidth   = 32;           // operand / result word
   localparam int regIdxWidth = 5;            // 32 architectural registers

   // index that always reads as zero, never forwarded
   localparam logic [regIdxWidth-1:0] zeroReg = 5'd31;

   //////////////////////////////////////////////////////////////////////
   // register address and data types
   //////////////////////////////////////////////////////////////////////

   // msb is the valid flag, as on the decode side of the pipe
   typedef struct packed {
      logic                   valid;          // 1 => address in use
      logic [regIdxWidth-1:0] idx;            // register number
   } regAddrT;                                // 6 bits

   typedef logic [dataWidth-1:0] regDataT;    // one word of register data

endpackage
